//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = regFileTb
FILELIST = all.f

OBJDIR   = obj_dir
SIM      = $(OBJDIR)/V$(TOP)
SOURCES  = $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(OBJDIR)

//--- all.f
hw/isaPkg.sv
hw/regFilePkg.sv
hw/fetchLatch.sv
hw/portDecoder.sv
hw/regSlot.sv
hw/readCombiner.sv
hw/pcUnit.sv
hw/regFileCore.sv
tests/clockGen.sv
tests/regFileTb.sv

//--- hw/fetchLatch.sv
// fetch/decode latch
// captures an instruction with the counter value and splits it into fields
`default_nettype none

module fetchLatch
  import isaPkg::*;
(
  input  logic        clk,
  input  logic        clr,
  input  wordT        instr,
  input  logic        instrLoad,
  input  wordT        pc,
  output instrFieldsT fields
);

  instrFieldsT nextFields;

  // field split, positions overlap on purpose
  always_comb
  begin
    nextFields.cond           = instr[31:28];
    nextFields.linkBit        = instr[24];
    nextFields.setFlags       = instr[20];
    nextFields.rn             = instr[19:16];
    nextFields.rd             = instr[15:12];
    nextFields.rm             = instr[3:0];
    nextFields.shifterOperand = instr[11:0];
    nextFields.offset24       = instr[23:0];
    // counter as seen at the capture edge
    nextFields.fetchPc        = pc;
  end

  always_ff @(posedge clk, negedge clr)
  begin
    if (!clr)
      fields <= '0;
    else if (instrLoad)
      fields <= nextFields;
  end

  // a captured instruction must be fully defined
  instrKnown: assert property (@(posedge clk) disable iff (!clr)
    instrLoad |-> !$isunknown(instr));

endmodule

`default_nettype wire

//--- hw/isaPkg.sv
// instruction set definitions for the operand side
// field layout of a fetched instruction, register numbers and counter constants
`default_nettype none

package isaPkg;

  // register number, 0 to 15
  typedef logic [3:0] regIndexT;

  // data and address word
  typedef logic [31:0] wordT;

  // decoded fetch/decode latch contents
  typedef struct packed {
    logic [3:0]  cond;
    logic        linkBit;
    logic        setFlags;
    regIndexT    rn;
    regIndexT    rd;
    regIndexT    rm;
    logic [11:0] shifterOperand;
    logic [23:0] offset24;
    wordT        fetchPc;
  } instrFieldsT;

  // entry 15 is the program counter
  localparam regIndexT PcIndex = 4'd15;

  // one word per fetch
  localparam wordT DefaultPcStep = 32'd4;

endpackage

`default_nettype wire

//--- hw/pcUnit.sv
// program counter, entry 15 of the register file
// write beats clear, clear beats step, otherwise hold
`default_nettype none

module pcUnit
  import isaPkg::*;
#(
  parameter wordT PcStep = DefaultPcStep
)
(
  input  logic clk,
  input  logic clr,
  input  logic pcWrite,
  input  wordT writeData,
  input  logic pcReset,
  input  logic pcLoad,
  output wordT pc
);

  wordT pcNext;

  // write to 15 first, then clear, then step
  always_comb
  begin
    if (pcWrite)
      pcNext = writeData;
    else if (pcReset)
      pcNext = '0;
    else if (pcLoad)
      pcNext = pc + PcStep;
    else
      pcNext = pc;
  end

  always_ff @(posedge clk, negedge clr)
  begin
    if (!clr)
      pc <= '0;
    else
      pc <= pcNext;
  end

  // counter controls defined on every edge out of reset
  controlsKnown: assert property (@(posedge clk) disable iff (!clr)
    !$isunknown({pcWrite, pcReset, pcLoad}));

endmodule

`default_nettype wire

//--- hw/portDecoder.sv
// write and read index decoder
// turns the write address and three read indexes into one-hot strobes
`default_nettype none

module portDecoder
  import isaPkg::*, regFilePkg::*;
(
  input  logic     writeEn,
  input  regIndexT writeAddr,
  input  readSelT  sel,
  output oneHotT   writeHot,
  output oneHotT   readHotA,
  output oneHotT   readHotB,
  output oneHotT   readHotD,
  output logic     pcWrite
);

  oneHotT addrHot;

  // plain binary to one-hot
  always_comb
  begin
    addrHot = '0;
    addrHot[writeAddr] = 1'b1;
  end

  // no strobe at all without writeEn
  assign writeHot = writeEn ? addrHot : '0;

  // entry 15 goes to the counter instead of a slot
  assign pcWrite = writeHot[PcIndex];

  // read side is never gated
  always_comb
  begin
    readHotA = '0;
    readHotB = '0;
    readHotD = '0;
    readHotA[sel.portA] = 1'b1;
    readHotB[sel.portB] = 1'b1;
    readHotD[sel.portD] = 1'b1;
  end

endmodule

`default_nettype wire

//--- hw/readCombiner.sv
// read port combiner
// ORs the slot contributions per port and puts the counter on index 15
`default_nettype none

module readCombiner
  import isaPkg::*, regFilePkg::*;
(
  input  slotOutT slots [NumGeneral],
  input  wordT    pc,
  input  oneHotT  readHotA,
  input  oneHotT  readHotB,
  input  oneHotT  readHotD,
  output wordT    operandA,
  output wordT    operandB,
  output wordT    operandD
);

  oneHotT portHot [NumPorts];
  wordT   merged  [NumPorts];
  wordT   operand [NumPorts];

  // port order A, B, D throughout
  assign portHot[0] = readHotA;
  assign portHot[1] = readHotB;
  assign portHot[2] = readHotD;

  // unselected slots give zero, so a plain OR picks the one selected
  always_comb
  begin
    merged[0] = '0;
    merged[1] = '0;
    merged[2] = '0;
    for (int s = 0; s < NumGeneral; s++)
    begin
      merged[0] = merged[0] | slots[s].portA;
      merged[1] = merged[1] | slots[s].portB;
      merged[2] = merged[2] | slots[s].portD;
    end
  end

  for (genvar p = 0; p < NumPorts; p++)
  begin : gPort
    // counter replaces the slot result on index 15
    assign operand[p] = portHot[p][PcIndex] ? pc : merged[p];

    // every read selects exactly one entry
    always_comb
    begin
      readOneHot: assert final ($onehot(portHot[p]));
    end
  end

  assign operandA = operand[0];
  assign operandB = operand[1];
  assign operandD = operand[2];

endmodule

`default_nettype wire

//--- hw/regFileCore.sv
// operand side top level
// fetch/decode latch feeding three read ports of the register file
`default_nettype none

module regFileCore
  import isaPkg::*, regFilePkg::*;
#(
  parameter wordT PcStep = DefaultPcStep
)
(
  input  logic        clk,
  input  logic        clr,
  input  wordT        instr,
  input  logic        instrLoad,
  input  logic        writeEn,
  input  regIndexT    writeAddr,
  input  wordT        writeData,
  input  logic        pcLoad,
  input  logic        pcReset,
  output instrFieldsT fields,
  output wordT        operandA,
  output wordT        operandB,
  output wordT        operandD,
  output wordT        pc
);

  readSelT sel;
  oneHotT  writeHot;
  oneHotT  readHotA;
  oneHotT  readHotB;
  oneHotT  readHotD;
  logic    pcWrite;
  slotOutT slotContrib [NumGeneral];

  fetchLatch i_fetchLatch (
    .clk       (clk),
    .clr       (clr),
    .instr     (instr),
    .instrLoad (instrLoad),
    .pc        (pc),
    .fields    (fields)
  );

  // rn to A, rm to B, rd to D
  assign sel.portA = fields.rn;
  assign sel.portB = fields.rm;
  assign sel.portD = fields.rd;

  portDecoder i_portDecoder (
    .writeEn   (writeEn),
    .writeAddr (writeAddr),
    .sel       (sel),
    .writeHot  (writeHot),
    .readHotA  (readHotA),
    .readHotB  (readHotB),
    .readHotD  (readHotD),
    .pcWrite   (pcWrite)
  );

  // general registers 0 to 14
  for (genvar i = 0; i < NumGeneral; i++)
  begin : gSlot
    regSlot i_regSlot (
      .clk       (clk),
      .clr       (clr),
      .load      (writeHot[i]),
      .writeData (writeData),
      .hotA      (readHotA[i]),
      .hotB      (readHotB[i]),
      .hotD      (readHotD[i]),
      .contrib   (slotContrib[i])
    );
  end

  readCombiner i_readCombiner (
    .slots    (slotContrib),
    .pc       (pc),
    .readHotA (readHotA),
    .readHotB (readHotB),
    .readHotD (readHotD),
    .operandA (operandA),
    .operandB (operandB),
    .operandD (operandD)
  );

  pcUnit #(
    .PcStep (PcStep)
  ) i_pcUnit (
    .clk       (clk),
    .clr       (clr),
    .pcWrite   (pcWrite),
    .writeData (writeData),
    .pcReset   (pcReset),
    .pcLoad    (pcLoad),
    .pc        (pc)
  );

endmodule

`default_nettype wire

//--- hw/regFilePkg.sv
// register file storage and port types
// read select bundle, one-hot strobes and per-slot read contributions
`default_nettype none

package regFilePkg;

  import isaPkg::*;

  // three read ports, A, B and D
  localparam int NumPorts = 3;

  // general registers 0 to 14, the counter sits outside the slot array
  localparam int NumGeneral = 15;

  // read indexes taken from the latched instruction
  typedef struct packed {
    regIndexT portA;
    regIndexT portB;
    regIndexT portD;
  } readSelT;

  // one bit per register file entry
  typedef logic [15:0] oneHotT;

  // what one slot puts on each read port, zero when not selected
  typedef struct packed {
    wordT portA;
    wordT portB;
    wordT portD;
  } slotOutT;

endpackage

`default_nettype wire

//--- hw/regSlot.sv
// one general register
// loads on its own strobe and drives each read port it is selected on
`default_nettype none

module regSlot
  import isaPkg::*, regFilePkg::*;
(
  input  logic    clk,
  input  logic    clr,
  input  logic    load,
  input  wordT    writeData,
  input  logic    hotA,
  input  logic    hotB,
  input  logic    hotD,
  output slotOutT contrib
);

  wordT value;

  always_ff @(posedge clk, negedge clr)
  begin
    if (!clr)
      value <= '0;
    else if (load)
      value <= writeData;
  end

  // and-gating per port
  // combiner ORs all slots together
  assign contrib.portA = hotA ? value : '0;
  assign contrib.portB = hotB ? value : '0;
  assign contrib.portD = hotD ? value : '0;

endmodule

`default_nettype wire

//--- tests/clockGen.sv
// testbench clock source
// free-running clock, low for the first half period
`default_nettype none

module clockGen #(
  parameter int Period = 40
)
(
  output logic clk
);

  initial
  begin
    clk = 1'b0;
    // toggle every half period
    forever
      #(Period / 2) clk = ~clk;
  end

endmodule

`default_nettype wire

//--- tests/regFileTb.sv
// testbench for the operand side top level
// drives writes, instruction loads and counter controls against a reference model
`default_nettype none

module regFileTb
  import isaPkg::*;
;

  localparam int   ClkPeriod = 40;
  localparam wordT PcStep    = DefaultPcStep;

  logic        clk;
  logic        clr;
  wordT        instr;
  logic        instrLoad;
  logic        writeEn;
  regIndexT    writeAddr;
  wordT        writeData;
  logic        pcLoad;
  logic        pcReset;
  instrFieldsT fields;
  wordT        operandA;
  wordT        operandB;
  wordT        operandD;
  wordT        pc;

  // reference state, entry 15 is the counter
  wordT        refRegs [16];
  instrFieldsT refFields;
  int          valueErrors   = 0;
  int          timeoutErrors = 0;

  clockGen #(.Period(ClkPeriod)) i_clockGen (.clk(clk));

  regFileCore #(
    .PcStep (PcStep)
  ) i_regFileCore (
    .clk       (clk),
    .clr       (clr),
    .instr     (instr),
    .instrLoad (instrLoad),
    .writeEn   (writeEn),
    .writeAddr (writeAddr),
    .writeData (writeData),
    .pcLoad    (pcLoad),
    .pcReset   (pcReset),
    .fields    (fields),
    .operandA  (operandA),
    .operandB  (operandB),
    .operandD  (operandD),
    .pc        (pc)
  );

  // field split by the bit table, counter taken at the load edge
  function automatic instrFieldsT expectFields(input wordT ins, input wordT pcNow);
    instrFieldsT f;
    f.cond           = ins[31:28];
    f.linkBit        = ins[24];
    f.setFlags       = ins[20];
    f.rn             = ins[19:16];
    f.rd             = ins[15:12];
    f.rm             = ins[3:0];
    f.shifterOperand = ins[11:0];
    f.offset24       = ins[23:0];
    f.fetchPc        = pcNow;
    return f;
  endfunction

  task automatic checkWord(input string name, input wordT got, input wordT want);
    assert (got === want)
    else
    begin
      valueErrors++;
      $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, want);
    end
  endtask

  // one cycle of inputs, applied on the falling edge
  task automatic driveCycle(input logic we, input regIndexT addr, input wordT data,
                            input logic load, input wordT ins, input logic step,
                            input logic clear);
    @(negedge clk);
    writeEn   = we;
    writeAddr = addr;
    writeData = data;
    instrLoad = load;
    instr     = ins;
    pcLoad    = step;
    pcReset   = clear;
  endtask

  task automatic waitForPc(input wordT target, input int limit);
    int waited;
    waited = 0;
    while (pc !== target && waited < limit)
    begin
      @(negedge clk);
      waited++;
    end
    if (pc !== target)
    begin
      timeoutErrors++;
      $display("timeout: pc did not reach %h within %0d cycles", target, limit);
    end
  endtask

  // model update, fields use the counter before this edge
  always @(posedge clk or negedge clr)
  begin : modelUpdate
    wordT nextPc;
    if (!clr)
    begin
      for (int r = 0; r < 16; r++)
        refRegs[r] = '0;
      refFields = '0;
    end
    else
    begin
      if (instrLoad)
        refFields = expectFields(instr, refRegs[15]);
      if (writeEn && writeAddr != PcIndex)
        refRegs[writeAddr] = writeData;
      // write to 15 first, then clear, then step
      if (writeEn && writeAddr == PcIndex)
        nextPc = writeData;
      else if (pcReset)
        nextPc = '0;
      else if (pcLoad)
        nextPc = refRegs[15] + PcStep;
      else
        nextPc = refRegs[15];
      refRegs[15] = nextPc;
    end
  end

  // compare late in the high phase, outputs settle right after the rising edge
  always @(posedge clk)
  begin
    #(ClkPeriod / 2 - 5);
    if (clr)
    begin
      assert (fields === refFields)
      else
      begin
        valueErrors++;
        $display("FAILED at %0t: fields = %h, expected %h", $time, fields, refFields);
      end
      checkWord("operandA", operandA, refRegs[refFields.rn]);
      checkWord("operandB", operandB, refRegs[refFields.rm]);
      checkWord("operandD", operandD, refRegs[refFields.rd]);
      checkWord("pc", pc, refRegs[15]);
    end
  end

  initial
  begin
    wordT ins;
    wordT target;
    wordT pcValue;
    int   stretch;
    clr       = 1'b0;
    instr     = '0;
    instrLoad = 1'b0;
    writeEn   = 1'b0;
    writeAddr = '0;
    writeData = '0;
    pcLoad    = 1'b0;
    pcReset   = 1'b0;
    void'($urandom(32'h68a20afd));

    // reset, then everything reads zero
    repeat (10) @(negedge clk);
    clr = 1'b1;
    assert (fields === '0)
    else
    begin
      valueErrors++;
      $display("FAILED at %0t: fields = %h, expected 0", $time, fields);
    end
    checkWord("operandA", operandA, '0);
    checkWord("operandB", operandB, '0);
    checkWord("operandD", operandD, '0);
    checkWord("pc", pc, '0);

    // fill general registers, then read them through loaded instructions
    for (int n = 0; n < 40; n++)
      driveCycle(1'b1, regIndexT'($urandom % 15), $urandom, 1'b0, instr, 1'b0, 1'b0);
    for (int n = 0; n < 20; n++)
      driveCycle(1'b0, '0, '0, 1'b1, $urandom, 1'b0, 1'b0);

    // counter stretches, step each edge while pcLoad is high
    for (int s = 0; s < 6; s++)
    begin
      stretch = 1 + ($urandom % 8);
      target  = refRegs[15] + wordT'(stretch) * PcStep;
      driveCycle(1'b0, '0, '0, 1'b0, instr, 1'b1, 1'b0);
      waitForPc(target, 12);
      pcLoad = 1'b0;
    end
    // clear beats step
    driveCycle(1'b0, '0, '0, 1'b0, instr, 1'b1, 1'b1);
    driveCycle(1'b0, '0, '0, 1'b0, instr, 1'b0, 1'b0);
    checkWord("pc", pc, '0);

    // write to 15 beats clear and step, then read it on all ports
    pcValue = $urandom;
    driveCycle(1'b1, PcIndex, pcValue, 1'b0, instr, 1'b1, 1'b1);
    ins        = $urandom;
    ins[19:16] = PcIndex;
    ins[15:12] = PcIndex;
    ins[3:0]   = PcIndex;
    driveCycle(1'b0, '0, '0, 1'b1, ins, 1'b0, 1'b0);
    driveCycle(1'b0, '0, '0, 1'b0, ins, 1'b0, 1'b0);
    checkWord("pc", pc, pcValue);
    checkWord("operandA", operandA, pcValue);
    checkWord("operandB", operandB, pcValue);
    checkWord("operandD", operandD, pcValue);
    // operands follow the counter while it steps
    for (int n = 0; n < 4; n++)
      driveCycle(1'b0, '0, '0, 1'b0, ins, 1'b1, 1'b0);

    // random mix, fields hold whenever instrLoad is low
    for (int n = 0; n < 60; n++)
      driveCycle(($urandom % 2) == 1, regIndexT'($urandom % 16), $urandom,
                 ($urandom % 2) == 1, $urandom, ($urandom % 2) == 1, ($urandom % 8) == 0);

    repeat (3) driveCycle(1'b0, '0, '0, 1'b0, instr, 1'b0, 1'b0);
    $display("errors: %0d value mismatches, %0d timeouts", valueErrors, timeoutErrors);
    if (valueErrors == 0 && timeoutErrors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire
